/* files.f */
hdl/scope_pkg.sv
hdl/cmd_ctrl.sv
hdl/config_regs.sv
hdl/readout_engine.sv
hdl/scope_proc.sv
testbench/tb_capture_ram.sv
testbench/tb_scope_proc.sv

/* hdl/cmd_ctrl.sv */
// bytes are taken on every rx_valid with no back-pressure; a SELECT for this board is ignored while a readout runs
`timescale 1ns/1ps

module cmd_ctrl import scope_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              rx_valid,
	input  logic [BYTE_W-1:0] rx_data,
	input  logic [BYTE_W-1:0] board_id,
	input  logic              cap_ready,
	input  logic              rd_done,
	output logic              fwd_valid,
	output logic [BYTE_W-1:0] fwd_data,
	output cfg_write_t        cfg_wr,
	output logic              rd_start
);

	ctrl_state_e            state;        // readout sequencing
	opcode_e                pend_op;      // opcode still collecting arguments
	logic [1:0]             args_left;    // argument bytes still to come
	logic [BYTE_W-1:0]      arg_hi;       // first argument byte, 0 for one-byte args
	logic                   passthrough;  // some other board is selected
	logic [READY_TMO_W-1:0] tmo_cnt;      // cycles spent waiting on cap_ready
	logic [1:0]             nargs;        // arguments the byte on rx_data needs
	logic                   known_op;
	logic                   is_set_id;
	logic                   is_select;
	logic                   is_last;
	logic [BYTE_W-1:0]      sel_id;       // id addressed by a SELECT
	logic [BYTE_W-1:0]      last_id;      // id addressed by a LAST

	assign is_set_id = rx_data < (OP_SET_ID + RANGE_SPAN);
	assign is_select = (rx_data >= OP_SELECT) && (rx_data < (OP_SELECT + RANGE_SPAN));
	assign is_last   = (rx_data >= OP_LAST) && (rx_data < (OP_LAST + RANGE_SPAN));
	assign sel_id    = rx_data - OP_SELECT;
	assign last_id   = rx_data - OP_LAST;

	always_comb begin
		nargs    = 2'd0;
		known_op = 1'b1;
		case (rx_data)
			OP_TRIG_POINT, OP_SAMPLES, OP_TIME_OVER: nargs = 2'd2;   // high byte then low
			OP_SEND_SHIFT, OP_PACE, OP_THRESH_LO, OP_TRIG_TYPE,
			OP_TRIG_CHAN, OP_THRESH_HI:              nargs = 2'd1;
			OP_ARM, OP_ROLL_ON, OP_ROLL_OFF, OP_AUTOREARM: nargs = 2'd0;
			default:                                 known_op = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= CS_IDLE;
			pend_op     <= OP_ARM;
			args_left   <= 2'd0;
			arg_hi      <= '0;
			passthrough <= 1'b0;
			tmo_cnt     <= '0;
			fwd_valid   <= 1'b0;
			fwd_data    <= '0;
			cfg_wr      <= '0;
			rd_start    <= 1'b0;
		end else begin
			fwd_valid     <= 1'b0;   // all three are single-cycle pulses
			cfg_wr.strobe <= 1'b0;
			rd_start      <= 1'b0;

			case (state)
				CS_WAIT_READY: begin
					if (passthrough) begin
						state <= CS_IDLE;                  // host moved on to another board
					end else if (cap_ready) begin
						rd_start <= 1'b1;
						state    <= CS_READOUT;
					end else if (tmo_cnt == READY_TMO_W'(READY_TIMEOUT - 1)) begin
						state <= CS_IDLE;                  // capture never completed, give up
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				CS_READOUT: begin
					if (rd_done) state <= CS_IDLE;
				end
				default: ;
			endcase

			if (rx_valid) begin
				if (args_left != 2'd0) begin               // argument byte
					fwd_valid <= 1'b1;
					fwd_data  <= rx_data;
					arg_hi    <= rx_data;
					args_left <= args_left - 2'd1;
					if (args_left == 2'd1) begin           // last one, hand the write over
						cfg_wr.strobe <= 1'b1;
						cfg_wr.opcode <= pend_op;
						cfg_wr.arg_hi <= arg_hi;
						cfg_wr.arg_lo <= rx_data;
					end
				end else if (is_set_id) begin
					fwd_valid     <= 1'b1;
					fwd_data      <= rx_data + 1'b1;       // next board down gets the next id
					cfg_wr.strobe <= 1'b1;
					cfg_wr.opcode <= OP_SET_ID;
					cfg_wr.arg_hi <= '0;
					cfg_wr.arg_lo <= rx_data;
				end else if (is_select) begin
					if (sel_id == board_id) begin          // us: not forwarded
						passthrough <= 1'b0;
						if (state == CS_IDLE) begin
							state   <= CS_WAIT_READY;
							tmo_cnt <= '0;
						end
					end else begin
						passthrough <= 1'b1;
						fwd_valid   <= 1'b1;
						fwd_data    <= rx_data;
					end
				end else if (is_last) begin
					fwd_valid     <= 1'b1;
					fwd_data      <= rx_data;
					cfg_wr.strobe <= 1'b1;
					cfg_wr.opcode <= OP_LAST;
					cfg_wr.arg_hi <= '0;
					cfg_wr.arg_lo <= {{(BYTE_W - 1){1'b0}}, last_id == board_id};
				end else if (known_op) begin
					fwd_valid <= 1'b1;
					fwd_data  <= rx_data;
					if (nargs == 2'd0) begin
						cfg_wr.strobe <= 1'b1;
						cfg_wr.opcode <= opcode_e'(rx_data);
						cfg_wr.arg_hi <= '0;
						cfg_wr.arg_lo <= '0;
					end else begin
						pend_op   <= opcode_e'(rx_data);
						args_left <= nargs;
						arg_hi    <= '0;                   // stays 0 for one-byte args
					end
				end
				// anything else is dropped here and not passed on
			end
		end
	end

endmodule

/* hdl/config_regs.sv */
// writes land one cycle after the strobe; TRIG_CHAN only touches this board's four channels
`timescale 1ns/1ps

module config_regs import scope_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  cfg_write_t        cfg_wr,
	output logic [BYTE_W-1:0] board_id,
	output trig_cfg_t         trig_cfg,
	output readout_cfg_t      ro_cfg,
	output logic              last_board,
	output logic              arm
);

	logic [2*BYTE_W-1:0] arg_word;      // high byte then low
	logic [RAM_AW-1:0]   new_samples;
	logic [RAM_AW-1:0]   tp_clamped;
	logic [PACE_W-1:0]   pace_clamped;

	assign arg_word    = {cfg_wr.arg_hi, cfg_wr.arg_lo};
	assign new_samples = arg_word[RAM_AW-1:0];

	always_comb begin
		if (arg_word > (RAM_DEPTH - TP_MAX_MARGIN))
			tp_clamped = RAM_AW'(RAM_DEPTH - TP_MAX_MARGIN);
		else if (arg_word < TP_MIN)
			tp_clamped = RAM_AW'(TP_MIN);
		else
			tp_clamped = arg_word[RAM_AW-1:0];
	end

	assign pace_clamped = (cfg_wr.arg_lo > PACE_MAX) ? PACE_W'(PACE_MAX) : cfg_wr.arg_lo[PACE_W-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			board_id           <= UNASSIGNED_ID;
			last_board         <= 1'b0;
			arm                <= 1'b0;
			trig_cfg.thresh_lo <= THRESH_LO_RESET;
			trig_cfg.thresh_hi <= THRESH_HI_RESET;
			trig_cfg.trig_type <= TRIG_TYPE_RESET;
			trig_cfg.chan_en   <= '1;
			trig_cfg.time_over <= '0;
			trig_cfg.rolling   <= 1'b1;
			ro_cfg.trig_point  <= TP_RESET;     // quarter of the buffer before the trigger
			ro_cfg.samples     <= '0;
			ro_cfg.send_shift  <= '0;
			ro_cfg.pace_shift  <= PACE_RESET;
			ro_cfg.autorearm   <= 1'b0;
		end else begin
			arm <= 1'b0;
			if (cfg_wr.strobe) begin
				case (cfg_wr.opcode)
					OP_SET_ID:     board_id <= cfg_wr.arg_lo;
					OP_LAST:       last_board <= cfg_wr.arg_lo[0];   // id match done upstream
					OP_ARM:        arm <= 1'b1;
					OP_ROLL_ON:    trig_cfg.rolling <= 1'b1;
					OP_ROLL_OFF:   trig_cfg.rolling <= 1'b0;
					OP_AUTOREARM:  ro_cfg.autorearm <= !ro_cfg.autorearm;
					OP_TRIG_POINT: ro_cfg.trig_point <= tp_clamped;
					OP_SAMPLES: begin
						ro_cfg.samples <= new_samples;
						// short windows pull the trigger point to the middle, unclamped
						if (new_samples >= RAM_AW'(SAMPLE_GAP) &&
							ro_cfg.trig_point > new_samples - RAM_AW'(SAMPLE_GAP))
							ro_cfg.trig_point <= new_samples >> 1;
					end
					OP_SEND_SHIFT: ro_cfg.send_shift <= cfg_wr.arg_lo[SHIFT_W-1:0];
					OP_PACE:       ro_cfg.pace_shift <= pace_clamped;
					OP_THRESH_LO:  trig_cfg.thresh_lo <= cfg_wr.arg_lo;
					OP_THRESH_HI:  trig_cfg.thresh_hi <= cfg_wr.arg_lo;
					OP_TRIG_TYPE:  trig_cfg.trig_type <= cfg_wr.arg_lo[TYPE_W-1:0];
					OP_TIME_OVER:  trig_cfg.time_over <= arg_word[RAM_AW:0];
					OP_TRIG_CHAN: begin
						if ((cfg_wr.arg_lo >> CH_W) == board_id)   // arg/4 picks the board
							trig_cfg.chan_en[cfg_wr.arg_lo[CH_W-1:0]] <=
								!trig_cfg.chan_en[cfg_wr.arg_lo[CH_W-1:0]];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/readout_engine.sv */
// RAM answers rd_addr one cycle later; settings other than the start address are read live during a readout
`timescale 1ns/1ps

module readout_engine import scope_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              rd_start,
	input  logic [RAM_AW-1:0] wr_trig_addr,
	input  readout_cfg_t      ro_cfg,
	input  sample_quad_t      ram_data,
	input  logic              tx_busy,
	output logic [RAM_AW-1:0] rd_addr,
	output logic              tx_start,
	output logic [BYTE_W-1:0] tx_data,
	output logic              rd_done,
	output logic              rearm
);

	rd_state_e              state;
	logic [RAM_AW-1:0]      base;         // first sample address of every channel
	logic [CH_W-1:0]        ch_f;         // channel being fetched
	logic [CH_W-1:0]        rd_ch;        // channel of the read in flight
	logic [OFF_W-1:0]       off_f;        // offset being fetched
	logic                   fetch_done;   // last address issued
	logic                   rd_pend;      // ram_data holds our read this cycle
	logic                   hold_valid;
	logic [BYTE_W-1:0]      hold_byte;    // next byte for the transmitter
	logic [PACE_CNT_W-1:0]  pace_cnt;     // cycles since the last tx_start, saturating
	logic [OFF_W-1:0]       n_lim;
	logic [OFF_W-1:0]       step;
	logic [OFF_W-1:0]       off_next;
	logic                   pace_ok;
	logic                   send_now;
	logic                   issue;

	assign n_lim    = (ro_cfg.samples == '0) ? OFF_W'(RAM_DEPTH) : OFF_W'(ro_cfg.samples);
	assign step     = OFF_W'(1) << ro_cfg.send_shift;
	assign off_next = off_f + step;
	assign pace_ok  = pace_cnt >= ((PACE_CNT_W'(1) << ro_cfg.pace_shift) - PACE_CNT_W'(1));

	// never two starts in a row, and busy is only sampled with tx_start low
	assign send_now = (state == RD_RUN) && hold_valid && !tx_busy && !tx_start && pace_ok;
	// refill as soon as the holding byte is empty or leaving this cycle
	assign issue    = (state == RD_RUN) && !fetch_done && !rd_pend && (!hold_valid || send_now);
	assign rd_addr  = base + off_f[RAM_AW-1:0];   // wraps mod depth

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= RD_IDLE;
			base       <= '0;
			ch_f       <= '0;
			rd_ch      <= '0;
			off_f      <= '0;
			fetch_done <= 1'b0;
			rd_pend    <= 1'b0;
			hold_valid <= 1'b0;
			hold_byte  <= '0;
			pace_cnt   <= '1;
			tx_start   <= 1'b0;
			tx_data    <= '0;
			rd_done    <= 1'b0;
			rearm      <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			rd_done  <= 1'b0;
			rearm    <= 1'b0;
			rd_pend  <= issue;
			if (pace_cnt != '1) pace_cnt <= pace_cnt + 1'b1;

			case (state)
				RD_IDLE: begin
					if (rd_start) begin
						base       <= wr_trig_addr - ro_cfg.trig_point;
						ch_f       <= '0;
						off_f      <= '0;
						fetch_done <= 1'b0;
						hold_valid <= 1'b0;
						pace_cnt   <= '1;            // first byte goes without pacing
						state      <= RD_RUN;
					end
				end
				RD_RUN: begin
					if (issue) begin
						rd_ch <= ch_f;
						if (off_next >= n_lim) begin  // channel finished
							off_f <= '0;
							if (ch_f == CH_W'(NUM_CH - 1))
								fetch_done <= 1'b1;
							else
								ch_f <= ch_f + 1'b1;
						end else begin
							off_f <= off_next;
						end
					end
					if (rd_pend) begin
						hold_byte  <= ram_data[rd_ch];
						hold_valid <= 1'b1;
					end else if (send_now) begin
						hold_valid <= 1'b0;
					end
					if (send_now) begin
						tx_start <= 1'b1;
						tx_data  <= hold_byte;
						pace_cnt <= '0;
						if (fetch_done && !rd_pend)  // nothing left behind this byte
							state <= RD_FINISH;
					end
				end
				RD_FINISH: begin
					rd_done <= 1'b1;
					rearm   <= ro_cfg.autorearm;
					state   <= RD_IDLE;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

/* hdl/scope_pkg.sv */
// sizes assume a 4096-deep, four-channel capture RAM with one byte per sample per channel
package scope_pkg;

	localparam int RAM_AW        = 12;                // capture RAM address bits
	localparam int RAM_DEPTH     = 1 << RAM_AW;       // samples per channel
	localparam int NUM_CH        = 4;
	localparam int CH_W          = $clog2(NUM_CH);
	localparam int BYTE_W        = 8;
	localparam int TP_MIN        = 4;                 // lowest trigger point accepted
	localparam int TP_MAX_MARGIN = 16;                // top trigger point sits this far below depth
	localparam int SAMPLE_GAP    = 5;                 // SAMPLES pulls the trigger point in past this
	localparam int PACE_MAX      = 30;                // largest pacing exponent
	localparam int PACE_W        = 5;
	localparam int PACE_CNT_W    = PACE_MAX + 1;      // holds 2^PACE_MAX - 1
	localparam int SHIFT_W       = 4;                 // send shift field
	localparam int TYPE_W        = 4;                 // trigger type field
	localparam int OFF_W         = RAM_AW + 5;        // offset plus the widest step without wrap
	localparam int READY_TIMEOUT = 1 << 20;           // cycles to wait for cap_ready
	localparam int READY_TMO_W   = $clog2(READY_TIMEOUT);

	localparam logic [BYTE_W-1:0] UNASSIGNED_ID   = 8'd200;
	localparam logic [BYTE_W-1:0] RANGE_SPAN      = 8'd10;  // width of the id ranges
	localparam logic [BYTE_W-1:0] THRESH_LO_RESET = 8'h80;
	localparam logic [BYTE_W-1:0] THRESH_HI_RESET = 8'hFF;
	localparam logic [TYPE_W-1:0] TRIG_TYPE_RESET = 4'b0001; // rising edge only
	localparam logic [PACE_W-1:0] PACE_RESET      = 5'd5;
	localparam logic [RAM_AW-1:0] TP_RESET        = RAM_AW'(RAM_DEPTH / 4);

	// range commands are named by their base value
	typedef enum logic [BYTE_W-1:0] {
		OP_SET_ID     = 8'd0,
		OP_SELECT     = 8'd10,
		OP_LAST       = 8'd20,
		OP_ARM        = 8'd100,
		OP_ROLL_ON    = 8'd101,
		OP_ROLL_OFF   = 8'd102,
		OP_TRIG_POINT = 8'd121,
		OP_SAMPLES    = 8'd122,
		OP_SEND_SHIFT = 8'd123,
		OP_PACE       = 8'd125,
		OP_THRESH_LO  = 8'd127,
		OP_TRIG_TYPE  = 8'd128,
		OP_TIME_OVER  = 8'd129,
		OP_TRIG_CHAN  = 8'd130,
		OP_AUTOREARM  = 8'd139,
		OP_THRESH_HI  = 8'd140
	} opcode_e;

	typedef enum logic [1:0] {CS_IDLE, CS_WAIT_READY, CS_READOUT} ctrl_state_e;
	typedef enum logic [1:0] {RD_IDLE, RD_RUN, RD_FINISH} rd_state_e;

	typedef struct packed {
		logic              strobe;
		opcode_e           opcode;
		logic [BYTE_W-1:0] arg_hi;   // first argument byte
		logic [BYTE_W-1:0] arg_lo;   // second, or the only one
	} cfg_write_t;

	typedef struct packed {
		logic [BYTE_W-1:0] thresh_lo;
		logic [BYTE_W-1:0] thresh_hi;
		logic [TYPE_W-1:0] trig_type;
		logic [NUM_CH-1:0] chan_en;
		logic [RAM_AW:0]   time_over;
		logic              rolling;
	} trig_cfg_t;

	typedef struct packed {
		logic [RAM_AW-1:0]  trig_point;
		logic [RAM_AW-1:0]  samples;    // 0 means the full depth
		logic [SHIFT_W-1:0] send_shift;
		logic [PACE_W-1:0]  pace_shift;
		logic               autorearm;
	} readout_cfg_t;

	typedef logic [NUM_CH-1:0][BYTE_W-1:0] sample_quad_t; // channel 0 in the low byte

endpackage

/* hdl/scope_proc.sv */
// one board of the chain; trig_arm merges ARM commands and autorearm at the end of a readout
`timescale 1ns/1ps

module scope_proc import scope_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              rx_valid,
	input  logic [BYTE_W-1:0] rx_data,
	output logic              fwd_valid,
	output logic [BYTE_W-1:0] fwd_data,
	input  logic              tx_busy,
	output logic              tx_start,
	output logic [BYTE_W-1:0] tx_data,
	input  logic              cap_ready,
	input  logic [RAM_AW-1:0] wr_trig_addr,
	output logic              trig_arm,
	output logic [RAM_AW-1:0] rd_addr,
	input  sample_quad_t      ram_data,
	output trig_cfg_t         trig_cfg,
	output logic              last_board
);

	cfg_write_t        cfg_wr;
	readout_cfg_t      ro_cfg;
	logic [BYTE_W-1:0] board_id;
	logic              rd_start;
	logic              rd_done;
	logic              cfg_arm;    // ARM command
	logic              rearm;      // autorearm after a readout

	assign trig_arm = cfg_arm | rearm;   // both are registered pulses

	cmd_ctrl u_cmd_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.board_id  (board_id),
		.cap_ready (cap_ready),
		.rd_done   (rd_done),
		.fwd_valid (fwd_valid),
		.fwd_data  (fwd_data),
		.cfg_wr    (cfg_wr),
		.rd_start  (rd_start)
	);

	config_regs u_config_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_wr     (cfg_wr),
		.board_id   (board_id),
		.trig_cfg   (trig_cfg),
		.ro_cfg     (ro_cfg),
		.last_board (last_board),
		.arm        (cfg_arm)
	);

	readout_engine u_readout_engine (
		.clk          (clk),
		.arst_n       (arst_n),
		.rd_start     (rd_start),
		.wr_trig_addr (wr_trig_addr),
		.ro_cfg       (ro_cfg),
		.ram_data     (ram_data),
		.tx_busy      (tx_busy),
		.rd_addr      (rd_addr),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.rd_done      (rd_done),
		.rearm        (rearm)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and exits non-zero unless it passed
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_scope_proc -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_scope_proc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* testbench/tb_capture_ram.sv */
// read-only behavioural capture RAM with one cycle read latency; contents are fixed at time zero
`timescale 1ns/1ps

module tb_capture_ram import scope_pkg::*; (
	input  logic              clk,
	input  logic [RAM_AW-1:0] rd_addr,
	output sample_quad_t      ram_data
);

	logic [BYTE_W-1:0] mem [NUM_CH][RAM_DEPTH];   // one byte lane per channel

	initial begin
		ram_data = '0;
		for (int c = 0; c < NUM_CH; c++)
			for (int a = 0; a < RAM_DEPTH; a++)
				mem[c][a] = BYTE_W'(a + 37 * c + (a >> 8));   // page number folded in
	end

	// all four channels answer together
	always @(posedge clk) begin
		for (int c = 0; c < NUM_CH; c++)
			ram_data[c] <= mem[c][rd_addr];
	end

endmodule

/* testbench/tb_scope_proc.sv */
// directed tests for one chain board; expects the DUT to start as an unassigned board after reset
`timescale 1ns/1ps

module tb_scope_proc import scope_pkg::*; ();

	localparam int RD_TIMEOUT  = 20000;   // cycles allowed for one whole readout
	localparam int ARM_TIMEOUT = 20;
	localparam int QUIET       = 64;      // idle cycles that show a readout is over

	logic              clk = 1'b0;
	logic              arst_n;
	logic              rx_valid;
	logic [BYTE_W-1:0] rx_data;
	logic              fwd_valid;
	logic [BYTE_W-1:0] fwd_data;
	logic              tx_busy = 1'b0;
	logic              tx_start;
	logic [BYTE_W-1:0] tx_data;
	logic              cap_ready;
	logic [RAM_AW-1:0] wr_trig_addr;
	logic              trig_arm;
	logic [RAM_AW-1:0] rd_addr;
	sample_quad_t      ram_data;
	trig_cfg_t         trig_cfg;
	logic              last_board;

	integer seed         = 32'h9f7d52b0;
	int     errors       = 0;
	int     checks       = 0;
	string  test_name    = "reset";
	int     cyc          = 0;                  // negedge count
	int     busy_len     = 0;                  // busy cycles the transmitter still owes
	logic   busy_seen    = 1'b0;               // tx_busy as the DUT sampled it last edge
	int     pace_exp     = int'(PACE_RESET);   // pacing the DUT should be using
	int     tx_q[$];                           // every byte handed to the transmitter
	int     last_tx_cyc  = 0;
	int     arm_cnt      = 0;
	int     last_arm_cyc = 0;

	scope_proc u_scope_proc (.*);

	tb_capture_ram u_capture_ram (
		.clk      (clk),
		.rd_addr  (rd_addr),
		.ram_data (ram_data)
	);

	always #5 clk = ~clk;

	task automatic report_failure(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic check_value(input string label, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test_name, label, exp, act);
		end
	endtask

	// transmitter model and output monitor, mid-cycle where outputs are settled
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (tx_start) begin
			assert (!busy_seen) else report_failure("tx_start raised while tx_busy was high");
			if (tx_q.size() != 0)
				assert (cyc - last_tx_cyc >= (1 << pace_exp)) else
					report_failure($sformatf("tx_start only %0d cycles apart", cyc - last_tx_cyc));
			tx_q.push_back(int'(tx_data));
			last_tx_cyc = cyc;
			busy_len    = $unsigned($random(seed)) % 8;   // 0 to 7 busy cycles
		end
		if (trig_arm) begin
			arm_cnt++;
			last_arm_cyc = cyc;
		end
		busy_seen = tx_busy;
	end

	always begin
		@(posedge clk);
		#1;
		tx_busy = (busy_len != 0);
		if (busy_len != 0) busy_len = busy_len - 1;
	end

	// expected sample, same rule as the RAM model fill
	function automatic int ram_byte(input int addr, input int ch);
		return (addr + 37 * ch + addr / 256) % 256;
	endfunction

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one receiver byte; a spare cycle follows so any setting has landed on return
	task automatic send_byte(input logic [BYTE_W-1:0] b, input bit fwd_exp,
		input logic [BYTE_W-1:0] fwd_val);
		rx_valid = 1'b1;
		rx_data  = b;
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		check_value($sformatf("fwd_valid for 0x%0h", b), int'(fwd_exp), int'(fwd_valid));
		if (fwd_exp)
			check_value($sformatf("fwd_data for 0x%0h", b), int'(fwd_val), int'(fwd_data));
		@(posedge clk);
		#1;
	endtask

	task automatic send_op(input logic [BYTE_W-1:0] op);
		send_byte(op, 1'b1, op);
	endtask

	task automatic send_op_arg(input logic [BYTE_W-1:0] op, input logic [BYTE_W-1:0] arg);
		send_byte(op, 1'b1, op);
		send_byte(arg, 1'b1, arg);   // arguments pass down the chain too
	endtask

	task automatic send_op_word(input logic [BYTE_W-1:0] op, input int word);
		send_byte(op, 1'b1, op);
		send_byte(BYTE_W'(word >> 8), 1'b1, BYTE_W'(word >> 8));
		send_byte(BYTE_W'(word), 1'b1, BYTE_W'(word));
	endtask

	// select this board and compare every transmitted byte with the expected stream
	task automatic readout_check(input logic [BYTE_W-1:0] sel, input int wta, input int tp,
		input int samples, input int shift);
		int n;
		int base;
		int first;
		int got;
		int t;
		int exp_q[$];
		n    = (samples == 0) ? RAM_DEPTH : samples;
		base = (wta - tp + RAM_DEPTH) % RAM_DEPTH;
		for (int ch = 0; ch < NUM_CH; ch++)
			for (int off = 0; off < n; off += (1 << shift))
				exp_q.push_back(ram_byte((base + off) % RAM_DEPTH, ch));
		first        = tx_q.size();
		wr_trig_addr = RAM_AW'(wta);
		cap_ready    = 1'b1;
		send_byte(sel, 1'b0, 8'h00);   // own select is consumed here
		t = 0;
		while (tx_q.size() - first < exp_q.size() && t < RD_TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (t < RD_TIMEOUT) else report_failure("readout did not deliver all bytes in time");
		idle_cycles(QUIET);
		got = tx_q.size() - first;
		check_value("byte count", exp_q.size(), got);
		for (int i = 0; i < exp_q.size() && i < got; i++)
			check_value($sformatf("byte %0d", i), exp_q[i], tx_q[first + i]);
	endtask

	task automatic test_id_chain();
		test_name = "id_chain";
		send_byte(8'd3, 1'b1, 8'd4);                      // next board gets id 4
		send_op_arg(OP_PACE, 8'd0);
		pace_exp = 0;
		send_op_word(OP_SAMPLES, 4);                      // too short to move the trigger point
		readout_check(8'd13, 1030, RAM_DEPTH / 4, 4, 0);  // only id 3 answers SELECT 13
	endtask

	task automatic test_passthrough();
		int first;
		test_name = "passthrough";
		first     = tx_q.size();
		send_byte(8'd15, 1'b1, 8'd15);
		idle_cycles(200);
		check_value("tx bytes while another board selected", first, tx_q.size());
	endtask

	task automatic test_settings();
		test_name = "settings";
		send_op_word(OP_TRIG_POINT, 16'h0FFF);
		readout_check(8'd13, 20, RAM_DEPTH - TP_MAX_MARGIN, 4, 0);   // clamped at the top
		send_op_arg(OP_THRESH_LO, 8'h42);
		check_value("thresh_lo", 'h42, int'(trig_cfg.thresh_lo));
		send_op_arg(OP_TRIG_TYPE, 8'h06);
		check_value("trig_type", 'h6, int'(trig_cfg.trig_type));
		send_op_arg(OP_TRIG_CHAN, 8'd14);                 // board 3, channel 2
		check_value("chan_en", 'hB, int'(trig_cfg.chan_en));
		check_value("thresh_hi", 'hFF, int'(trig_cfg.thresh_hi));
		send_op_word(OP_TIME_OVER, 16'h3456);
		check_value("time_over", 16'h3456 % (2 * RAM_DEPTH), int'(trig_cfg.time_over));  // 13 bits
		send_op(OP_ROLL_OFF);
		check_value("rolling", 0, int'(trig_cfg.rolling));
		send_op(8'd23);                                   // LAST for id 3
		check_value("last_board", 1, int'(last_board));
	endtask

	task automatic test_readout_content();
		test_name = "readout_content";
		send_op_word(OP_SAMPLES, 8);                      // 4080 is past 8-5, drops to 4
		send_op_word(OP_TRIG_POINT, 1);                   // clamped up to TP_MIN
		send_op_arg(OP_SEND_SHIFT, 8'd1);
		send_op_arg(OP_PACE, 8'd2);
		pace_exp = 2;
		readout_check(8'd13, 100, TP_MIN, 8, 1);          // addresses 96 98 100 102
	endtask

	task automatic test_autorearm();
		int arms;
		int t;
		test_name = "autorearm";
		send_op_word(OP_TRIG_POINT, 10);
		send_op_word(OP_SAMPLES, 6);                      // 10 > 6-5 so trigger point is 3
		send_op(OP_AUTOREARM);
		arms = arm_cnt;
		readout_check(8'd13, 2, 3, 6, 1);                 // start wraps to 4095
		check_value("trig_arm pulses after readout", arms + 1, arm_cnt);
		assert (last_arm_cyc > last_tx_cyc) else report_failure("trig_arm not after last tx_start");
		arms = arm_cnt;
		send_op(OP_ARM);
		t = 0;
		while (arm_cnt == arms && t < ARM_TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (t < ARM_TIMEOUT) else report_failure("no trig_arm after ARM");
		idle_cycles(10);
		check_value("trig_arm pulses after ARM", arms + 1, arm_cnt);
	endtask

	initial begin
		arst_n       = 1'b0;
		rx_valid     = 1'b0;
		rx_data      = '0;
		cap_ready    = 1'b0;
		wr_trig_addr = '0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_value("thresh_lo", 'h80, int'(trig_cfg.thresh_lo));
		check_value("chan_en", 'hF, int'(trig_cfg.chan_en));
		check_value("rolling", 1, int'(trig_cfg.rolling));
		check_value("trig_type", 'h1, int'(trig_cfg.trig_type));
		check_value("time_over", 0, int'(trig_cfg.time_over));
		check_value("last_board", 0, int'(last_board));
		check_value("tx_start", 0, int'(tx_start));
		check_value("fwd_valid", 0, int'(fwd_valid));
		check_value("trig_arm", 0, int'(trig_arm));
		test_id_chain();
		test_passthrough();
		test_settings();
		test_readout_content();
		test_autorearm();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
